//--- source/i8008_pkg.sv
package i8008_pkg;

  localparam int ADDR_W = 14;

  typedef logic [7:0]        byte_t;
  typedef logic [ADDR_W-1:0] pc_t;

  // Original 8008 state codes as seen on S2..S0
  typedef enum logic [2:0] {
    WAIT    = 3'b000,
    T3      = 3'b001,
    T1      = 3'b010,
    STOPPED = 3'b011,
    T2      = 3'b100,
    T5      = 3'b101,
    T4      = 3'b111
  } state_t;

  typedef enum logic [1:0] {
    CYCLE1 = 2'd0,
    CYCLE2 = 2'd1,
    CYCLE3 = 2'd2
  } cycle_t;

  // Sent in bits 7:6 of the high address byte
  typedef enum logic [1:0] {
    PCI = 2'd0,
    PCR = 2'd1,
    PCC = 2'd2,
    PCW = 2'd3
  } cycle_type_t;

  // First eight codes match instruction bits 5:3
  typedef enum logic [3:0] {
    ADD, ADC, SUB, SBB, ANA, XRA, ORA, CMP,
    INR, DCR, RLC, RRC, RAL, RAR
  } alu_op_t;

  typedef enum logic [2:0] {
    REG_A = 3'd0,
    REG_B = 3'd1,
    REG_C = 3'd2,
    REG_D = 3'd3,
    REG_E = 3'd4,
    REG_H = 3'd5,
    REG_L = 3'd6
  } reg_sel_t;

  typedef enum logic [1:0] {COND_C, COND_Z, COND_S, COND_P} cond_t;

  typedef enum logic [3:0] {
    OP_MOV, OP_LRI, OP_INR, OP_DCR, OP_ALU_R, OP_ALU_I, OP_ROT,
    OP_JMP, OP_JCC, OP_CAL, OP_RET, OP_OUT, OP_HLT, OP_ILLEGAL
  } op_class_t;

  typedef enum logic [2:0] {
    SRC_NONE, SRC_ADDR, SRC_RF, SRC_ALU, SRC_A, SRC_B, SRC_DATA
  } bus_src_t;

  typedef struct packed {
    logic carry;
    logic zero;
    logic sign;
    logic parity;
  } flags_t;

endpackage

//--- source/i8008_ctrl_if.sv
`timescale 1ns/10ps

interface i8008_ctrl_if
  import i8008_pkg::*;
(
  input logic clk
);

  bus_src_t    bus_src;
  logic        ir_load;
  logic        rf_we;
  reg_sel_t    rf_sel;
  logic        a_we;
  logic        b_we;
  alu_op_t     alu_op;
  logic        flag_we;
  logic        pc_inc;
  logic        pc_wr_lo;
  logic        pc_wr_hi;
  logic        sp_push;
  logic        sp_pop;
  logic        addr_hi;     // High address byte instead of low
  cycle_type_t cycle_type;

  modport seq (
    input  clk,
    output bus_src, ir_load, rf_we, rf_sel, a_we, b_we, alu_op, flag_we,
    output pc_inc, pc_wr_lo, pc_wr_hi, sp_push, sp_pop, addr_hi, cycle_type
  );

  modport dp_alu   (input clk, a_we, b_we, alu_op, flag_we);
  modport dp_rf    (input clk, rf_we, rf_sel);
  modport dp_stack (input clk, pc_inc, pc_wr_lo, pc_wr_hi, sp_push, sp_pop, addr_hi, cycle_type);
  modport dp_core  (input clk, bus_src, ir_load, cycle_type);

endinterface

//--- source/i8008_sequencer.sv
`timescale 1ns/10ps

module i8008_sequencer
  import i8008_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      ready,
  input  byte_t     instr,
  input  flags_t    flags,
  i8008_ctrl_if.seq ctrl,
  output state_t    state
);

  logic        ready_meta;
  logic        ready_sync;
  cycle_t      cycle;
  cycle_t      next_cycle;
  state_t      next_state;
  op_class_t   op_class;
  cycle_type_t cyc_type;
  logic        mem_cycle;
  logic        cond_flag;
  logic        cond_ok;
  reg_sel_t    ddd;
  reg_sel_t    sss;

  assign ddd = reg_sel_t'(instr[5:3]);
  assign sss = reg_sel_t'(instr[2:0]);

  always_ff @(posedge clk) begin
    if (rst) begin
      ready_meta <= 1'b0;
      ready_sync <= 1'b0;
    end else begin
      ready_meta <= ready;
      ready_sync <= ready_meta;
    end
  end

  // Instruction classes kept in this core
  always_comb begin
    op_class = OP_ILLEGAL;
    case (instr[7:6])
      2'b00: begin
        if (instr[5:1] == 5'b00000) begin
          op_class = OP_HLT;
        end else begin
          case (instr[2:0])
            3'b000:  if (instr[5:3] != 3'b111) op_class = OP_INR;
            3'b001:  if (instr[5:3] != 3'b111) op_class = OP_DCR;
            3'b010:  if (!instr[5]) op_class = OP_ROT;
            3'b100:  op_class = OP_ALU_I;
            3'b110:  if (instr[5:3] != 3'b111) op_class = OP_LRI;
            3'b111:  op_class = OP_RET;
            default: op_class = OP_ILLEGAL;   // RST and conditional return
          endcase
        end
      end
      2'b01: begin
        if (instr[2:0] == 3'b100) op_class = OP_JMP;
        else if (instr[2:0] == 3'b110) op_class = OP_CAL;
        else if (instr[2:0] == 3'b000) op_class = OP_JCC;
        else if (instr[0] && instr[5:4] != 2'b00) op_class = OP_OUT;   // Port 0..7 is INP
      end
      2'b10: if (instr[2:0] != 3'b111) op_class = OP_ALU_R;
      default: begin
        if (instr == 8'hFF) op_class = OP_HLT;
        else if (instr[5:3] != 3'b111 && instr[2:0] != 3'b111) op_class = OP_MOV;
      end
    endcase
  end

  always_comb begin
    case (cond_t'(instr[4:3]))
      COND_C:  cond_flag = flags.carry;
      COND_Z:  cond_flag = flags.zero;
      COND_S:  cond_flag = flags.sign;
      default: cond_flag = flags.parity;
    endcase
  end

  assign cond_ok = (cond_flag == instr[5]);   // Bit 5 set for jump on true

  always_comb begin
    if (cycle == CYCLE1) cyc_type = PCI;
    else if (cycle == CYCLE2 && op_class == OP_OUT) cyc_type = PCC;
    else cyc_type = PCR;
  end

  assign mem_cycle       = (cyc_type != PCC);
  assign ctrl.cycle_type = cyc_type;
  assign ctrl.ir_load    = (state == T3) && (cycle == CYCLE1);

  always_comb begin
    case (op_class)
      OP_INR:  ctrl.alu_op = INR;
      OP_DCR:  ctrl.alu_op = DCR;
      OP_ROT: begin
        case (instr[4:3])
          2'd0:    ctrl.alu_op = RLC;
          2'd1:    ctrl.alu_op = RRC;
          2'd2:    ctrl.alu_op = RAL;
          default: ctrl.alu_op = RAR;
        endcase
      end
      default: ctrl.alu_op = alu_op_t'({1'b0, instr[5:3]});
    endcase
  end

  always_comb begin
    next_state    = state;
    next_cycle    = cycle;
    ctrl.bus_src  = SRC_NONE;
    ctrl.rf_we    = 1'b0;
    ctrl.rf_sel   = REG_A;
    ctrl.a_we     = 1'b0;
    ctrl.b_we     = 1'b0;
    ctrl.flag_we  = 1'b0;
    ctrl.pc_inc   = 1'b0;
    ctrl.pc_wr_lo = 1'b0;
    ctrl.pc_wr_hi = 1'b0;
    ctrl.sp_push  = 1'b0;
    ctrl.sp_pop   = 1'b0;
    ctrl.addr_hi  = 1'b0;

    case (state)
      T1: begin
        next_state   = T2;
        ctrl.bus_src = mem_cycle ? SRC_ADDR : SRC_RF;   // OUT shows the accumulator
      end
      T2, WAIT: begin
        ctrl.bus_src = SRC_ADDR;
        ctrl.addr_hi = 1'b1;
        ctrl.pc_inc  = (state == T2) && mem_cycle;
        next_state   = ready_sync ? T3 : WAIT;
      end
      T3: begin
        case (cycle)
          CYCLE1: begin
            // Accumulator into A while the opcode arrives
            ctrl.bus_src = SRC_RF;
            ctrl.a_we    = 1'b1;
            case (op_class)
              OP_HLT:     next_state = STOPPED;
              OP_ILLEGAL: next_state = T1;
              OP_MOV, OP_INR, OP_DCR, OP_ALU_R, OP_ROT, OP_RET: next_state = T4;
              default: begin
                next_state = T1;
                next_cycle = CYCLE2;
              end
            endcase
          end
          CYCLE2: begin
            if (op_class == OP_OUT) begin
              next_state = T1;
              next_cycle = CYCLE1;
            end else begin
              ctrl.bus_src = SRC_DATA;   // Immediate or low target byte
              ctrl.b_we    = 1'b1;
              if (op_class == OP_LRI || op_class == OP_ALU_I) begin
                next_state = T4;
              end else begin
                next_state = T1;
                next_cycle = CYCLE3;
              end
            end
          end
          default: begin
            ctrl.bus_src = SRC_DATA;     // High target byte
            ctrl.a_we    = 1'b1;
            if (op_class == OP_JCC && !cond_ok) begin
              next_state = T1;
              next_cycle = CYCLE1;
            end else begin
              next_state = T4;
            end
          end
        endcase
      end
      T4: begin
        next_state = T5;
        case (op_class)
          OP_MOV, OP_ALU_R: begin
            ctrl.bus_src = SRC_RF;
            ctrl.rf_sel  = sss;
            ctrl.b_we    = 1'b1;
          end
          OP_INR, OP_DCR: begin
            ctrl.bus_src = SRC_RF;
            ctrl.rf_sel  = ddd;
            ctrl.a_we    = 1'b1;
          end
          OP_RET: ctrl.sp_pop = 1'b1;
          OP_JMP, OP_JCC, OP_CAL: begin
            ctrl.sp_push  = (op_class == OP_CAL);   // Target lands in the new entry
            ctrl.bus_src  = SRC_A;
            ctrl.pc_wr_hi = 1'b1;
          end
          default: ;
        endcase
      end
      T5: begin
        next_state = T1;
        next_cycle = CYCLE1;
        case (op_class)
          OP_MOV, OP_LRI: begin
            ctrl.bus_src = SRC_B;
            ctrl.rf_sel  = ddd;
            ctrl.rf_we   = 1'b1;
          end
          OP_INR, OP_DCR, OP_ALU_R, OP_ALU_I, OP_ROT: begin
            ctrl.bus_src = SRC_ALU;
            ctrl.rf_sel  = (op_class == OP_INR || op_class == OP_DCR) ? ddd : REG_A;
            ctrl.rf_we   = 1'b1;
            ctrl.flag_we = 1'b1;
          end
          OP_JMP, OP_JCC, OP_CAL: begin
            ctrl.bus_src  = SRC_B;
            ctrl.pc_wr_lo = 1'b1;
          end
          default: ;
        endcase
      end
      STOPPED: next_state = STOPPED;   // Left only through rst
      default: begin
        next_state = T1;
        next_cycle = CYCLE1;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= T1;
      cycle <= CYCLE1;
    end else begin
      state <= next_state;
      cycle <= next_cycle;
    end
  end

endmodule

//--- source/i8008_alu.sv
`timescale 1ns/10ps

module i8008_alu
  import i8008_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  byte_t        bus,
  i8008_ctrl_if.dp_alu ctrl,
  output byte_t        result,
  output byte_t        a_val,
  output byte_t        b_val,
  output flags_t       flags
);

  byte_t  a_reg;
  byte_t  b_reg;
  byte_t  cmp_diff;
  byte_t  flag_src;
  logic   carry_out;
  logic   rotate;
  flags_t flags_next;

  always_ff @(posedge clk) begin
    if (ctrl.a_we) a_reg <= bus;
    if (ctrl.b_we) b_reg <= bus;
  end

  assign a_val  = a_reg;
  assign b_val  = b_reg;
  assign rotate = ctrl.alu_op inside {RLC, RRC, RAL, RAR};

  always_comb begin
    result    = a_reg;
    cmp_diff  = 8'h00;
    carry_out = flags.carry;          // INR and DCR keep carry
    case (ctrl.alu_op)
      ADD: {carry_out, result} = {1'b0, a_reg} + {1'b0, b_reg};
      ADC: {carry_out, result} = {1'b0, a_reg} + {1'b0, b_reg} + 9'(flags.carry);
      SUB: {carry_out, result} = {1'b0, a_reg} - {1'b0, b_reg};   // Carry is borrow
      SBB: {carry_out, result} = {1'b0, a_reg} - {1'b0, b_reg} - 9'(flags.carry);
      ANA: begin
        result    = a_reg & b_reg;
        carry_out = 1'b0;
      end
      XRA: begin
        result    = a_reg ^ b_reg;
        carry_out = 1'b0;
      end
      ORA: begin
        result    = a_reg | b_reg;
        carry_out = 1'b0;
      end
      CMP: {carry_out, cmp_diff} = {1'b0, a_reg} - {1'b0, b_reg};   // A itself is returned
      INR: result = a_reg + 8'd1;
      DCR: result = a_reg - 8'd1;
      RLC: {carry_out, result} = {a_reg[7], a_reg[6:0], a_reg[7]};
      RRC: {result, carry_out} = {a_reg[0], a_reg[7:1], a_reg[0]};
      RAL: {carry_out, result} = {a_reg, flags.carry};
      RAR: {result, carry_out} = {flags.carry, a_reg};
      default: ;
    endcase
  end

  always_comb begin
    flag_src         = (ctrl.alu_op == CMP) ? cmp_diff : result;
    flags_next       = flags;
    flags_next.carry = carry_out;
    if (!rotate) begin
      flags_next.zero   = (flag_src == 8'h00);
      flags_next.sign   = flag_src[7];
      flags_next.parity = ~^flag_src;   // Even number of ones
    end
  end

  always_ff @(posedge clk) begin
    if (rst) flags <= '0;
    else if (ctrl.flag_we) flags <= flags_next;
  end

endmodule

//--- source/i8008_reg_file.sv
`timescale 1ns/10ps

module i8008_reg_file
  import i8008_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  byte_t       bus,
  i8008_ctrl_if.dp_rf ctrl,
  output byte_t       rf_out
);

  localparam int NUM_REGS = 7;   // A, B, C, D, E, H, L

  byte_t regs [NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= 8'h00;
      end
    end else if (ctrl.rf_we) begin
      regs[ctrl.rf_sel] <= bus;
    end
  end

  // Code 7 is the memory operand, not held here
  assign rf_out = (ctrl.rf_sel <= REG_L) ? regs[ctrl.rf_sel] : 8'h00;

endmodule

//--- source/i8008_addr_stack.sv
`timescale 1ns/10ps

module i8008_addr_stack
  import i8008_pkg::*;
#(
  parameter int STACK_DEPTH = 8
) (
  input  logic           clk,
  input  logic           rst,
  input  byte_t          bus,
  i8008_ctrl_if.dp_stack ctrl,
  output byte_t          addr_byte
);

  localparam int              SP_W   = $clog2(STACK_DEPTH);
  localparam logic [SP_W-1:0] SP_MAX = SP_W'(STACK_DEPTH - 1);

  pc_t             stack [STACK_DEPTH];
  logic [SP_W-1:0] sp;
  logic [SP_W-1:0] sp_next;
  pc_t             pc;

  assign pc = stack[sp];   // Top entry is the live PC

  // Saturating pointer at both ends
  always_comb begin
    sp_next = sp;
    if (ctrl.sp_push && sp != SP_MAX) begin
      sp_next = sp + 1'b1;
    end else if (ctrl.sp_pop && sp != '0) begin
      sp_next = sp - 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sp <= '0;
      for (int i = 0; i < STACK_DEPTH; i++) begin
        stack[i] <= '0;
      end
    end else begin
      sp <= sp_next;
      if (ctrl.pc_inc) begin
        stack[sp_next] <= pc + 1'b1;
      end
      if (ctrl.pc_wr_hi) begin
        stack[sp_next][ADDR_W-1:8] <= bus[ADDR_W-9:0];   // Call writes the pushed entry
      end
      if (ctrl.pc_wr_lo) begin
        stack[sp_next][7:0] <= bus;
      end
    end
  end

  assign addr_byte = ctrl.addr_hi ? {ctrl.cycle_type, pc[ADDR_W-1:8]} : pc[7:0];

endmodule

//--- source/i8008_core.sv
`timescale 1ns/10ps

module i8008_core
  import i8008_pkg::*;
#(
  parameter int STACK_DEPTH = 8
) (
  input  logic   clk,
  input  logic   rst,
  input  byte_t  d_in,
  input  logic   ready,
  output byte_t  d_out,
  output state_t state
);

  byte_t  ir;
  byte_t  instr;
  byte_t  bus;
  byte_t  alu_result;
  byte_t  a_val;
  byte_t  b_val;
  byte_t  rf_out;
  byte_t  addr_byte;
  flags_t flags;

  i8008_ctrl_if ctrl (.clk(clk));

  always_ff @(posedge clk) begin
    if (rst) ir <= 8'h00;
    else if (ctrl.ir_load) ir <= d_in;
  end

  assign instr = ctrl.ir_load ? d_in : ir;   // Decode the opcode while it is on d_in

  always_comb begin
    case (ctrl.bus_src)
      SRC_ADDR: begin
        if (ctrl.cycle_type == PCC) bus = {ctrl.cycle_type, ir[5:0]};   // OUT port in T2
        else bus = addr_byte;
      end
      SRC_RF:   bus = rf_out;
      SRC_ALU:  bus = alu_result;
      SRC_A:    bus = a_val;
      SRC_B:    bus = b_val;
      SRC_DATA: bus = d_in;
      default:  bus = 8'h00;
    endcase
  end

  assign d_out = bus;

  i8008_sequencer u_seq (
    .clk(clk), .rst(rst), .ready(ready), .instr(instr), .flags(flags), .ctrl(ctrl), .state(state)
  );

  i8008_alu u_alu (
    .clk(clk), .rst(rst), .bus(bus), .ctrl(ctrl), .result(alu_result),
    .a_val(a_val), .b_val(b_val), .flags(flags)
  );

  i8008_reg_file u_rf (.clk(clk), .rst(rst), .bus(bus), .ctrl(ctrl), .rf_out(rf_out));

  i8008_addr_stack #(.STACK_DEPTH(STACK_DEPTH)) u_stack (
    .clk(clk), .rst(rst), .bus(bus), .ctrl(ctrl), .addr_byte(addr_byte)
  );

endmodule

//--- tests/tb_i8008.sv
`timescale 1ns/10ps

module tb_i8008
  import i8008_pkg::*;
();

  localparam int    CLK_PERIOD  = 100;
  localparam int    IMAGE_SIZE  = 32768;
  localparam int    REC_BASE    = 16'h4000;   // Expected OUT records start here
  localparam int    RUN_TIMEOUT = 20000;
  localparam int    STOP_CYCLES = 20;
  localparam string TRACE_FILE  = "tests/i8008_trace.txt";

  logic   clk;
  logic   rst;
  logic   ready;
  byte_t  d_in;
  byte_t  d_out;
  state_t state;

  byte_t       image [IMAGE_SIZE];
  byte_t       exp_port [$];
  byte_t       exp_val [$];
  byte_t       got_port [$];
  byte_t       got_val [$];
  int          errors;
  int          timeouts;
  logic        random_ready;
  logic [31:0] seed;
  int          low_left;
  state_t      cur_state;
  byte_t       cur_dout;
  byte_t       lo_addr;
  logic [13:0] prev_addr;
  logic        first_check;
  int          t1_count;
  int          wait_cycles;
  int          base_waits;

  i8008_core #(.STACK_DEPTH(8)) u_dut (
    .clk(clk), .rst(rst), .d_in(d_in), .ready(ready), .d_out(d_out), .state(state)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // Outputs settle well before the falling edge
  always @(negedge clk) begin
    cur_state = state;
    cur_dout  = d_out;
  end

  // Random low stretches on ready in the second run
  always @(posedge clk) begin
    if (rst || !random_ready) begin
      ready    <= 1'b1;
      low_left <= 0;
    end else if (low_left > 0) begin
      ready    <= 1'b0;
      low_left <= low_left - 1;
    end else begin
      seed = lcg_next(seed);
      if (seed[30:28] < 3'd3) begin
        ready    <= 1'b0;
        low_left <= int'(seed[26:24]);
      end else begin
        ready <= 1'b1;
      end
    end
  end

  task automatic handle_t2();
    logic [13:0] addr;
    cycle_type_t ctype;
    addr  = {cur_dout[5:0], lo_addr};
    ctype = cycle_type_t'(cur_dout[7:6]);
    if (first_check) begin
      assert (lo_addr == 8'h00 && cur_dout == 8'h00) else begin
        errors++;
        $display("[ERROR] d_out first T1/T2 exp 00/00 got %02h/%02h", lo_addr, cur_dout);
      end
      first_check = 1'b0;
    end
    case (ctype)
      PCI: begin
        prev_addr = addr;
        d_in <= image[addr];
      end
      PCR: begin
        assert (addr == prev_addr + 14'd1) else begin
          errors++;
          $display("[ERROR] d_out operand address exp %04h got %04h", prev_addr + 14'd1, addr);
        end
        prev_addr = addr;
        d_in <= image[addr];
      end
      PCC: begin
        got_port.push_back({3'b000, cur_dout[5:1]});
        got_val.push_back(lo_addr);   // Accumulator shown in T1
        assert (lo_addr != 8'hEE) else begin
          errors++;
          $display("Marker value output, a not-taken path was executed");
        end
      end
      default: begin
        errors++;
        $display("Unexpected write cycle at address %04h", addr);
      end
    endcase
  endtask

  // Memory model follows the state pins
  always @(posedge clk) begin
    if (rst) begin
      d_in <= 8'h00;
      lo_addr     = 8'h00;
      prev_addr   = '0;
      first_check = 1'b1;
      t1_count    = 0;
      wait_cycles = 0;
      got_port.delete();
      got_val.delete();
    end else begin
      case (cur_state)
        T1: begin
          lo_addr = cur_dout;
          t1_count++;
        end
        T2:      handle_t2();
        WAIT:    wait_cycles++;
        default: ;
      endcase
    end
  end

  task automatic load_trace();
    int idx;
    for (int i = 0; i < IMAGE_SIZE; i++) begin
      image[i] = 8'(i ^ (i >> 8));
    end
    $readmemh(TRACE_FILE, image);
    idx = REC_BASE;
    while (idx < IMAGE_SIZE - 1 && image[idx] != 8'hFF) begin
      exp_port.push_back(image[idx]);
      exp_val.push_back(image[idx + 1]);
      idx += 2;
    end
  endtask

  task automatic run_program(input logic rnd);
    int cycles;
    int t1_before;
    @(posedge clk);
    rst          <= 1'b1;
    random_ready <= rnd;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (state != STOPPED && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
    end
    if (state != STOPPED) begin
      timeouts++;
      $display("Timeout: core did not halt within %0d cycles", RUN_TIMEOUT);
    end else begin
      t1_before = t1_count;
      for (int i = 0; i < STOP_CYCLES; i++) begin
        @(negedge clk);
        assert (state == STOPPED) else begin
          errors++;
          $display("[ERROR] state exp %01h got %01h", STOPPED, state);
        end
      end
      assert (t1_count == t1_before) else begin
        errors++;
        $display("Core started a new cycle after HLT");
      end
    end
  endtask

  task automatic check_outs(input int run);
    assert (got_port.size() == exp_port.size()) else begin
      errors++;
      $display("Run %0d gave %0d OUT records instead of %0d",
               run, got_port.size(), exp_port.size());
    end
    for (int i = 0; i < got_port.size() && i < exp_port.size(); i++) begin
      assert (got_port[i] == exp_port[i]) else begin
        errors++;
        $display("[ERROR] out_port[%0d] exp %02h got %02h", i, exp_port[i], got_port[i]);
      end
      assert (got_val[i] == exp_val[i]) else begin
        errors++;
        $display("[ERROR] out_val[%0d] exp %02h got %02h", i, exp_val[i], got_val[i]);
      end
    end
  endtask

  initial begin
    rst          = 1'b1;
    ready        = 1'b1;
    d_in         = 8'h00;
    random_ready = 1'b0;
    seed         = 32'd31999;
    low_left     = 0;
    errors       = 0;
    timeouts     = 0;
    base_waits   = 0;
    load_trace();
    assert (exp_port.size() > 0) else begin
      errors++;
      $display("No expected OUT records found in the trace file");
    end
    run_program(1'b0);   // Ready always high
    check_outs(1);
    base_waits = wait_cycles;   // WAITs seen with ready held high
    run_program(1'b1);
    check_outs(2);
    assert (wait_cycles > base_waits) else begin
      errors++;
      $display("Random ready stretches added no WAIT cycles");
    end
    $display("Summary: %0d errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
source/i8008_pkg.sv
source/i8008_ctrl_if.sv
source/i8008_sequencer.sv
source/i8008_alu.sv
source/i8008_reg_file.sv
source/i8008_addr_stack.sv
source/i8008_core.sv
tests/tb_i8008.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and look for the pass line in the output
verilator --binary --timing -f vlog.f --top-module tb_i8008 -o sim_i8008 \
  && ./obj_dir/sim_i8008 | tee /dev/stderr | grep -qF '*** TEST PASSED ***' \
  || { echo "Simulation did not pass"; exit 1; }

//--- tests/i8008_trace.txt
// Columns: @address, then bytes. 0000-3FFF is the program image,
// 4000 up holds expected OUT records as port/value pairs, ended by port FF
@0000 06 5A 51                 // LAI 5A, OUT 8
@0003 0E 33 C1 53              // LBI 33, LAB, OUT 9
@0007 80 55                    // ADD B, OUT 10
@0009 16 F0 82 8A 57           // LCI F0, ADD C, ADC C, OUT 11
@000E 91 99 59 99 5B           // SUB B, SBB B, OUT 12, SBB B, OUT 13
@0013 A2 A9 B1 5D B9 5F        // ANA C, XRA B, ORA B, OUT 14, CMP B, OUT 15
@0019 60 1F 00 70 22 00        // JTC not taken, JTS taken
@001F 06 EE 7F                 // Marker
@0022 40 28 00                 // JFC taken
@0025 06 EE 7F                 // Marker
@0028 78 25 00 68 25 00 50 25 00 58 37 00   // JTP, JTZ, JFS not taken, JFP taken
@0034 06 EE 7F                 // Marker
@0037 48 3D 00 06 EE 7F 61 A8  // JFZ taken, marker, OUT 16, XRA A
@003F 68 45 00 06 EE 7F        // JTZ taken
@0045 78 4B 00 06 EE 7F        // JTP taken
@004B 50 51 00 06 EE 7F        // JFS taken
@0051 48 34 00 58 34 00 70 34 00            // JFZ, JFP, JTS not taken
@005A 06 80 02 60 63 00 06 EE 7F            // LAI 80, RLC, JTC taken
@0063 40 34 00 63 0A 12 65 1A 1A 67 12 0C 00 69   // JFC no, rotates, ACI 00
@0071 2E FF 28 C5 6B 68 7C 00 06 EE 7F      // LHI FF, INR H, LAH, OUT 21, JTZ
@007C 31 70 83 00 06 EE 7F C6 6D            // DCR L, JTS, LAL, OUT 22
@0085 06 10 14 20 18 60 90 00 06 EE 7F      // LAI 10, SUI 20, INR D, JTC
@0090 C3 24 03 34 40 2C FF 6F               // LAD, NDI, ORI, XRI, OUT 23
@0098 04 44 1C 01 3C 01 71 60 A5 00 06 EE 7F   // ADI, SBI, CPI, OUT 24, JTC
@00A5 46 C0 00 73 44 B0 00 06 EE 7F         // CAL C0, OUT 25, JMP B0
@00B0 75 FF                    // OUT 26, HLT
@00C0 06 77 77 07              // Subroutine: LAI 77, OUT 27, RET
@4000 08 5A 09 33 0A 66 0B 47 0C E1 0D AD 0E B3 0F B3
@4010 10 B3 11 01 12 01 13 C0 14 81 15 00 16 FF 17 BE
@4020 18 00 1B 77 19 77 1A 77 FF
